// ==== Makefile ====
SIM_LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/tb_cpu: compile.f $(wildcard verilog/*.sv sim/*.sv)
	verilator --binary --timing --timescale 1ns/100ps -f compile.f --top-module tb_cpu -o tb_cpu

run: obj_dir/tb_cpu
	./obj_dir/tb_cpu 2>&1 | tee $(SIM_LOG)
	@if grep -q "FAIL: see errors above" $(SIM_LOG); then \
	  echo "Simulation failed"; \
	  exit 1; \
	fi
	@grep -q "PASS: all tests" $(SIM_LOG) || { echo "No pass line in $(SIM_LOG)"; exit 1; }

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps -f compile.f --top-module tb_cpu

clean:
	rm -rf obj_dir $(SIM_LOG)

// ==== compile.f ====
verilog/cpu_pkg.sv
verilog/cpu_clock_enable.sv
verilog/cpu_sequencer.sv
verilog/cpu_alu.sv
verilog/cpu_datapath.sv
verilog/cpu_top.sv
sim/tb_memory.sv
sim/tb_cpu.sv

// ==== sim/tb_cpu.sv ====
`default_nettype none

module tb_cpu;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned CLOCK_DIVIDER  = 4;
  localparam time         CLOCK_PERIOD   = 10ns;
  localparam time         DRIVE_DELAY    = 1ns;
  localparam int unsigned RESET_CYCLES   = 16;
  localparam int unsigned PROGRAM_BYTES  = 16;
  localparam int unsigned PRELOADS       = 3;
  localparam int unsigned STEPS_PER_CASE = 40;
  localparam int unsigned TIMEOUT_MARGIN = 4;

  // Each preload is {zero-page address, byte}
  localparam logic [0:PRELOADS-1][15:0] NO_PRELOAD = 48'hFF00_FF00_FF00;
  localparam logic [0:PRELOADS-1][15:0] ZP_BYTES   = 48'h409E_4127_42D3;

  typedef struct packed {
    cpu_pkg::addr_t                start_address;
    logic [0:PROGRAM_BYTES-1][7:0] program_bytes;
    logic [0:PRELOADS-1][15:0]     preloads;
    cpu_pkg::addr_t                expected_address;
    cpu_pkg::byte_t                expected_byte;
  } test_case_t;

  logic           clock = 1'b0;
  logic           reset;
  cpu_pkg::byte_t cpu_data_in;
  logic           cpu_data_valid;
  cpu_pkg::byte_t cpu_data_out;
  cpu_pkg::addr_t cpu_address;
  logic           cpu_bus_read;
  logic           cpu_bus_write;
  logic           load_enable;
  cpu_pkg::addr_t load_address;
  cpu_pkg::byte_t load_data;

  test_case_t  cases[$];
  string       case_names[$];
  int unsigned cycle_count   = 0;
  int unsigned timeout_limit = 0;

  cpu_top #(
    .CLOCK_DIVIDER(CLOCK_DIVIDER)
  ) cpu_top_inst (
    .clock_i     (clock),
    .reset_i     (reset),
    .data_i      (cpu_data_in),
    .data_valid_i(cpu_data_valid),
    .data_o      (cpu_data_out),
    .address_o   (cpu_address),
    .bus_read_o  (cpu_bus_read),
    .bus_write_o (cpu_bus_write)
  );

  tb_memory memory_inst (
    .clock_i       (clock),
    .address_i     (cpu_address),
    .data_i        (cpu_data_out),
    .bus_write_i   (cpu_bus_write),
    .load_i        (load_enable),
    .load_address_i(load_address),
    .load_data_i   (load_data),
    .data_o        (cpu_data_in),
    .data_valid_o  (cpu_data_valid)
  );

  always #(CLOCK_PERIOD / 2) clock = ~clock;

  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > timeout_limit) begin
      $display("Timeout: the DUT made no expected write within %0d cycles", timeout_limit);
      $display("FAIL: see errors above");
      $fatal(1, "Cycle limit reached");
    end
  end

  task automatic add_case(
    input string                         name,
    input cpu_pkg::addr_t                start_address,
    input logic [0:PROGRAM_BYTES-1][7:0] program_bytes,
    input logic [0:PRELOADS-1][15:0]     preloads,
    input cpu_pkg::addr_t                expected_address,
    input cpu_pkg::byte_t                expected_byte
  );
    test_case_t entry;
    entry.start_address    = start_address;
    entry.program_bytes    = program_bytes;
    entry.preloads         = preloads;
    entry.expected_address = expected_address;
    entry.expected_byte    = expected_byte;
    cases.push_back(entry);
    case_names.push_back(name);
  endtask

  // Programs read left to right from the start address, padded with NOP
  task automatic build_table();
    // Vector with a nonzero low byte
    add_case("lda_nop_sta", 16'hE123, 128'hA95C_EA85_10EA_EAEA_EAEA_EAEA_EAEA_EAEA,
             NO_PRELOAD, 16'h0010, 8'h5C);
    add_case("ldx_txa", 16'hC100, 128'hA237_8A85_11EA_EAEA_EAEA_EAEA_EAEA_EAEA,
             NO_PRELOAD, 16'h0011, 8'h37);
    add_case("ldy_tya", 16'hC200, 128'hA0C4_9885_12EA_EAEA_EAEA_EAEA_EAEA_EAEA,
             NO_PRELOAD, 16'h0012, 8'hC4);
    // A through X, S, X, A, Y and back to A
    add_case("stack_chain", 16'hC300, 128'hA981_AA9A_A900_BA8A_A8A9_0098_8513_EAEA,
             NO_PRELOAD, 16'h0013, 8'h81);
    add_case("lda_zp", 16'hC400, 128'hA540_8515_EAEA_EAEA_EAEA_EAEA_EAEA_EAEA,
             ZP_BYTES, 16'h0015, 8'h9E);
    add_case("ldx_zp", 16'hC500, 128'hA641_8A85_16EA_EAEA_EAEA_EAEA_EAEA_EAEA,
             ZP_BYTES, 16'h0016, 8'h27);
    add_case("ldy_zp", 16'hC600, 128'hA442_9885_17EA_EAEA_EAEA_EAEA_EAEA_EAEA,
             ZP_BYTES, 16'h0017, 8'hD3);
    // 3A + 25 + 0
    add_case("adc", 16'hC700, 128'hA93A_6925_8518_EAEA_EAEA_EAEA_EAEA_EAEA,
             NO_PRELOAD, 16'h0018, 8'h5F);
    // F0 + 30 gives 20 with carry, then 20 + 05 + 1
    add_case("adc_carry", 16'hC800, 128'hA9F0_6930_6905_8519_EAEA_EAEA_EAEA_EAEA,
             NO_PRELOAD, 16'h0019, 8'h26);
    // 50 - 10 - 1 with carry clear
    add_case("sbc_borrow", 16'hC900, 128'hA950_E910_851A_EAEA_EAEA_EAEA_EAEA_EAEA,
             NO_PRELOAD, 16'h001A, 8'h3F);
    // Jump over STA $30 to LDA #$42, STA $31
    add_case("jmp", 16'h8000, 128'hA9EE_4C07_8085_30A9_4285_31EA_EAEA_EAEA,
             NO_PRELOAD, 16'h0031, 8'h42);
  endtask

  task automatic load_byte(input cpu_pkg::addr_t address, input cpu_pkg::byte_t data);
    @(posedge clock);
    #DRIVE_DELAY;
    load_enable  = 1'b1;
    load_address = address;
    load_data    = data;
  endtask

  task automatic wait_for_write(output cpu_pkg::addr_t address, output cpu_pkg::byte_t data);
    @(negedge clock);
    while (!cpu_bus_write) begin
      @(negedge clock);
    end
    address = cpu_address;
    data    = cpu_data_out;
  endtask

  task automatic check_addr(
    input string          what,
    input cpu_pkg::addr_t expected,
    input cpu_pkg::addr_t actual
  );
    if (actual !== expected) begin
      $display("FAILED at %0t: %s expected %h, got %h", $time, what, expected, actual);
      $display("FAIL: see errors above");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic check_byte(
    input string          what,
    input cpu_pkg::byte_t expected,
    input cpu_pkg::byte_t actual
  );
    if (actual !== expected) begin
      $display("FAILED at %0t: %s expected %h, got %h", $time, what, expected, actual);
      $display("FAIL: see errors above");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic check_bit(
    input string what,
    input logic  expected,
    input logic  actual
  );
    if (actual !== expected) begin
      $display("FAILED at %0t: %s expected %b, got %b", $time, what, expected, actual);
      $display("FAIL: see errors above");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic run_case(input string name, input test_case_t tc);
    cpu_pkg::addr_t written_address;
    cpu_pkg::byte_t written_byte;
    @(posedge clock);
    #DRIVE_DELAY;
    reset = 1'b1;
    // Memory is loaded while the core is held in reset
    for (int i = 0; i < PROGRAM_BYTES; i++) begin
      load_byte(tc.start_address + cpu_pkg::addr_t'(i), tc.program_bytes[i]);
    end
    load_byte(16'hFFFC, tc.start_address[7:0]);
    load_byte(16'hFFFD, tc.start_address[15:8]);
    for (int i = 0; i < PRELOADS; i++) begin
      load_byte({8'h00, tc.preloads[i][15:8]}, tc.preloads[i][7:0]);
    end
    @(posedge clock);
    #DRIVE_DELAY;
    load_enable = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    #DRIVE_DELAY;
    // Bus levels held in reset point at the vector low byte
    check_addr({name, " address in reset"}, 16'hFFFC, cpu_address);
    check_bit({name, " read level in reset"}, 1'b1, cpu_bus_read);
    check_bit({name, " write level in reset"}, 1'b0, cpu_bus_write);
    reset = 1'b0;

    wait_for_write(written_address, written_byte);
    check_addr({name, " write address"}, tc.expected_address, written_address);
    check_byte({name, " write data"}, tc.expected_byte, written_byte);

    // The write lasts one step and gives way to the next opcode fetch
    repeat (CLOCK_DIVIDER - 1) @(negedge clock);
    check_bit({name, " write level in last cycle of step"}, 1'b1, cpu_bus_write);
    @(negedge clock);
    check_bit({name, " write level after one step"}, 1'b0, cpu_bus_write);
    check_bit({name, " read level after write"}, 1'b1, cpu_bus_read);
  endtask

  initial begin
    reset        = 1'b1;
    load_enable  = 1'b0;
    load_address = '0;
    load_data    = '0;
    build_table();
    timeout_limit = cases.size() * STEPS_PER_CASE * CLOCK_DIVIDER * TIMEOUT_MARGIN;

    foreach (cases[i]) begin
      run_case(case_names[i], cases[i]);
    end

    $display("PASS: all tests");
    $finish;
  end

endmodule : tb_cpu

`default_nettype wire

// ==== sim/tb_memory.sv ====
`default_nettype none

module tb_memory (
  input  wire                 clock_i,
  input  wire cpu_pkg::addr_t address_i,
  input  wire cpu_pkg::byte_t data_i,
  input  wire                 bus_write_i,
  input  wire                 load_i,
  input  wire cpu_pkg::addr_t load_address_i,
  input  wire cpu_pkg::byte_t load_data_i,
  output cpu_pkg::byte_t      data_o,
  output logic                data_valid_o
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned MEMORY_SIZE = 65536;
  localparam time         DRIVE_DELAY = 1ns;

  cpu_pkg::byte_t memory [MEMORY_SIZE];

  // Background byte mixes both halves of the address
  function automatic cpu_pkg::byte_t fill_byte(input cpu_pkg::addr_t address);
    return address[15:8] ^ {address[6:0], address[7]} ^ 8'h5A;
  endfunction

  // Writes are taken mid-cycle, when the bus levels are settled
  initial begin
    for (int unsigned a = 0; a < MEMORY_SIZE; a++) begin
      memory[a[15:0]] = fill_byte(a[15:0]);
    end
    forever begin
      @(negedge clock_i);
      if (load_i) begin
        memory[load_address_i] = load_data_i;
      end else if (bus_write_i) begin
        memory[address_i] = data_i;
      end
    end
  end

  // Read data and the ready level follow each rising edge
  initial begin
    void'($urandom(64));
    data_o       = '0;
    data_valid_o = 1'b0;
    forever begin
      @(posedge clock_i);
      #DRIVE_DELAY;
      data_o = memory[address_i];
      // Ready three cycles in four on average
      data_valid_o = ($urandom % 4) != 0;
    end
  end

endmodule : tb_memory

`default_nettype wire

// ==== verilog/cpu_alu.sv ====
`default_nettype none

module cpu_alu (
  input  wire cpu_pkg::byte_t   a_i,
  input  wire cpu_pkg::byte_t   b_i,
  input  wire                   carry_i,
  input  wire                   invert_i,
  input  wire cpu_pkg::status_t status_i,
  output cpu_pkg::byte_t        result_o,
  output cpu_pkg::status_t      flags_o
);

  cpu_pkg::byte_t operand_b;
  logic [8:0]     sum;

  // Inverted operand with carry in gives A - B - (1 - C)
  assign operand_b = invert_i ? ~b_i : b_i;
  assign sum       = {1'b0, a_i} + {1'b0, operand_b} + {8'd0, carry_i};
  assign result_o  = sum[7:0];

  always_comb begin
    flags_o   = status_i;
    flags_o.c = sum[8];
    flags_o.n = sum[7];
    flags_o.z = (sum[7:0] == 8'd0);
    // Same-sign inputs with a result of the other sign
    flags_o.v = (a_i[7] == operand_b[7]) && (sum[7] != a_i[7]);
  end

endmodule : cpu_alu

`default_nettype wire

// ==== verilog/cpu_clock_enable.sv ====
`default_nettype none

module cpu_clock_enable #(
  parameter int unsigned CLOCK_DIVIDER = 12
) (
  input  wire  clock_i,
  input  wire  reset_i,
  output logic step_tick_o
);

  // A divider of one still needs a one-bit counter
  localparam int unsigned COUNT_WIDTH = (CLOCK_DIVIDER > 1) ? $clog2(CLOCK_DIVIDER) : 1;
  localparam logic [COUNT_WIDTH-1:0] LAST_COUNT = COUNT_WIDTH'(CLOCK_DIVIDER - 1);

  logic [COUNT_WIDTH-1:0] count;

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      count       <= '0;
      step_tick_o <= 1'b0;
    end else if (count == LAST_COUNT) begin
      count       <= '0;
      step_tick_o <= 1'b1;
    end else begin
      count       <= count + 1'b1;
      step_tick_o <= 1'b0;
    end
  end

endmodule : cpu_clock_enable

`default_nettype wire

// ==== verilog/cpu_datapath.sv ====
`default_nettype none

module cpu_datapath (
  input  wire                    clock_i,
  input  wire                    reset_i,
  input  wire cpu_pkg::control_t control_i,
  input  wire cpu_pkg::byte_t    data_i,
  input  wire cpu_pkg::byte_t    alu_result_i,
  input  wire cpu_pkg::status_t  alu_flags_i,
  output cpu_pkg::byte_t         alu_a_o,
  output cpu_pkg::byte_t         alu_b_o,
  output logic                   alu_carry_o,
  output logic                   alu_invert_o,
  output cpu_pkg::status_t       alu_status_o,
  output cpu_pkg::addr_t         address_o,
  output cpu_pkg::byte_t         data_o,
  output logic                   bus_read_o,
  output logic                   bus_write_o
);

  cpu_pkg::byte_t   accumulator;
  cpu_pkg::byte_t   index_x;
  cpu_pkg::byte_t   index_y;
  cpu_pkg::byte_t   stack_pointer;
  cpu_pkg::status_t status;
  cpu_pkg::addr_t   program_counter;
  cpu_pkg::addr_t   pc_next;
  cpu_pkg::addr_t   address;
  cpu_pkg::byte_t   data_output;

  assign pc_next = program_counter + 16'd1;

  // ALU operands are zero when not selected
  assign alu_a_o      = control_i.alu.operand_a_sel ? accumulator : 8'd0;
  assign alu_b_o      = control_i.alu.operand_b_sel ? data_i : 8'd0;
  assign alu_carry_o  = status.c;
  assign alu_invert_o = control_i.alu.invert_b;
  assign alu_status_o = status;

  // Later strobes in each block take priority
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      status      <= cpu_pkg::STATUS_RESET;
      address     <= cpu_pkg::RESET_VECTOR;
      bus_read_o  <= 1'b1;
      bus_write_o <= 1'b0;
    end else begin
      if (control_i.pc_to_address) begin
        address <= program_counter;
      end
      if (control_i.increment_pc_to_address) begin
        address <= pc_next;
      end
      if (control_i.vector_high_to_address) begin
        address <= cpu_pkg::RESET_VECTOR + 16'd1;
      end
      if (control_i.data_to_address_low) begin
        address[7:0] <= data_i;
      end
      if (control_i.zero_page_high) begin
        address[15:8] <= cpu_pkg::ZERO_PAGE_HIGH;
      end
      if (control_i.data_to_address_high) begin
        address[15:8] <= data_i;
      end

      if (control_i.load_flags) begin
        status.n <= data_i[7];
        status.z <= (data_i == 8'd0);
      end
      if (control_i.alu.result_to_accumulator) begin
        status <= alu_flags_i;
      end

      // Bus levels only move on a step that issues an access
      if (control_i.bus_read || control_i.bus_write) begin
        bus_read_o  <= control_i.bus_read;
        bus_write_o <= control_i.bus_write;
      end
    end
  end

  always_ff @(posedge clock_i) begin
    if (control_i.data_to_pc_low) begin
      program_counter[7:0] <= data_i;
    end
    if (control_i.data_to_pc_high) begin
      program_counter[15:8] <= data_i;
    end
    if (control_i.increment_pc_to_pc) begin
      program_counter <= pc_next;
    end

    if (control_i.data_to_a) begin
      accumulator <= data_i;
    end
    if (control_i.x_to_a) begin
      accumulator <= index_x;
    end
    if (control_i.y_to_a) begin
      accumulator <= index_y;
    end
    if (control_i.alu.result_to_accumulator) begin
      accumulator <= alu_result_i;
    end

    if (control_i.data_to_x) begin
      index_x <= data_i;
    end
    if (control_i.a_to_x) begin
      index_x <= accumulator;
    end
    if (control_i.s_to_x) begin
      index_x <= stack_pointer;
    end

    if (control_i.data_to_y) begin
      index_y <= data_i;
    end
    if (control_i.a_to_y) begin
      index_y <= accumulator;
    end

    if (control_i.x_to_s) begin
      stack_pointer <= index_x;
    end
    if (control_i.a_to_data) begin
      data_output <= accumulator;
    end
  end

  assign address_o = address;
  assign data_o    = data_output;

endmodule : cpu_datapath

`default_nettype wire

// ==== verilog/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [15:0] addr_t;

  // 6502 encodings of the supported subset
  typedef enum logic [7:0] {
    OP_NOP     = 8'hEA,
    OP_TAX     = 8'hAA,
    OP_TAY     = 8'hA8,
    OP_TXA     = 8'h8A,
    OP_TYA     = 8'h98,
    OP_TXS     = 8'h9A,
    OP_TSX     = 8'hBA,
    OP_LDA_IMM = 8'hA9,
    OP_LDX_IMM = 8'hA2,
    OP_LDY_IMM = 8'hA0,
    OP_LDA_ZP  = 8'hA5,
    OP_LDX_ZP  = 8'hA6,
    OP_LDY_ZP  = 8'hA4,
    OP_STA_ZP  = 8'h85,
    OP_ADC_IMM = 8'h69,
    OP_SBC_IMM = 8'hE9,
    OP_JMP_ABS = 8'h4C
  } opcode_e;

  typedef enum logic [2:0] {
    FETCH       = 3'd0,
    OPERAND     = 3'd1,
    FINISH      = 3'd2,
    VECTOR_LOW  = 3'd6,
    VECTOR_HIGH = 3'd7
  } stage_e;

  // Bit 7 down to bit 0, as in the 6502 P register
  typedef struct packed {
    logic n;
    logic v;
    logic one;
    logic b;
    logic d;
    logic i;
    logic z;
    logic c;
  } status_t;

  localparam status_t STATUS_RESET = '{
    n: 1'b0, v: 1'b0, one: 1'b1, b: 1'b1, d: 1'b0, i: 1'b1, z: 1'b0, c: 1'b0
  };

  localparam addr_t RESET_VECTOR = 16'hFFFC;
  localparam byte_t ZERO_PAGE_HIGH = 8'h00;

  typedef struct packed {
    logic operand_a_sel;
    logic operand_b_sel;
    logic invert_b;
    logic result_to_accumulator;
  } alu_op_t;

  typedef struct packed {
    logic data_to_a;
    logic data_to_x;
    logic data_to_y;
    logic data_to_pc_low;
    logic data_to_pc_high;
    logic data_to_address_low;
    logic data_to_address_high;
    logic zero_page_high;
    logic increment_pc_to_pc;
    logic increment_pc_to_address;
    logic pc_to_address;
    logic vector_high_to_address;
    logic a_to_x;
    logic a_to_y;
    logic x_to_a;
    logic y_to_a;
    logic x_to_s;
    logic s_to_x;
    logic a_to_data;
    logic load_flags;
    logic bus_read;
    logic bus_write;
    alu_op_t alu;
  } control_t;

endpackage : cpu_pkg

`default_nettype wire

// ==== verilog/cpu_sequencer.sv ====
`default_nettype none

module cpu_sequencer (
  input  wire                     clock_i,
  input  wire                     reset_i,
  input  wire                     step_tick_i,
  input  wire cpu_pkg::byte_t     data_i,
  input  wire                     data_valid_i,
  output cpu_pkg::control_t       control_o
);

  cpu_pkg::stage_e   stage;
  cpu_pkg::stage_e   next_stage;
  cpu_pkg::opcode_e  instruction;
  cpu_pkg::control_t control;
  logic              needs_data;
  logic              latch_opcode;
  logic              single_byte;
  logic              advance;

  // Implied-mode opcodes have no operand byte
  always_comb begin
    case (data_i)
      cpu_pkg::OP_NOP, cpu_pkg::OP_TAX, cpu_pkg::OP_TAY, cpu_pkg::OP_TXA,
      cpu_pkg::OP_TYA, cpu_pkg::OP_TXS, cpu_pkg::OP_TSX: single_byte = 1'b1;
      default: single_byte = 1'b0;
    endcase
  end

  always_comb begin
    control      = '0;
    next_stage   = stage;
    needs_data   = 1'b1;
    latch_opcode = 1'b0;

    case (stage)
      cpu_pkg::VECTOR_LOW: begin
        control.data_to_pc_low         = 1'b1;
        control.vector_high_to_address = 1'b1;
        control.bus_read               = 1'b1;
        next_stage                     = cpu_pkg::VECTOR_HIGH;
      end

      cpu_pkg::VECTOR_HIGH: begin
        // First opcode address is the vector just read
        control.data_to_pc_high      = 1'b1;
        control.pc_to_address        = 1'b1;
        control.data_to_address_high = 1'b1;
        control.bus_read             = 1'b1;
        next_stage                   = cpu_pkg::FETCH;
      end

      cpu_pkg::FETCH: begin
        latch_opcode                    = 1'b1;
        control.bus_read                = 1'b1;
        control.increment_pc_to_pc      = !single_byte;
        control.increment_pc_to_address = !single_byte;
        next_stage                      = cpu_pkg::OPERAND;
      end

      cpu_pkg::OPERAND: begin
        // Most instructions end here with the next opcode fetch
        control.bus_read                = 1'b1;
        control.increment_pc_to_pc      = 1'b1;
        control.increment_pc_to_address = 1'b1;
        next_stage                      = cpu_pkg::FETCH;
        case (instruction)
          cpu_pkg::OP_TAX: begin
            needs_data     = 1'b0;
            control.a_to_x = 1'b1;
          end
          cpu_pkg::OP_TAY: begin
            needs_data     = 1'b0;
            control.a_to_y = 1'b1;
          end
          cpu_pkg::OP_TXA: begin
            needs_data     = 1'b0;
            control.x_to_a = 1'b1;
          end
          cpu_pkg::OP_TYA: begin
            needs_data     = 1'b0;
            control.y_to_a = 1'b1;
          end
          cpu_pkg::OP_TXS: begin
            needs_data     = 1'b0;
            control.x_to_s = 1'b1;
          end
          cpu_pkg::OP_TSX: begin
            needs_data     = 1'b0;
            control.s_to_x = 1'b1;
          end
          cpu_pkg::OP_LDA_IMM: begin
            control.data_to_a  = 1'b1;
            control.load_flags = 1'b1;
          end
          cpu_pkg::OP_LDX_IMM: begin
            control.data_to_x  = 1'b1;
            control.load_flags = 1'b1;
          end
          cpu_pkg::OP_LDY_IMM: begin
            control.data_to_y  = 1'b1;
            control.load_flags = 1'b1;
          end
          cpu_pkg::OP_ADC_IMM, cpu_pkg::OP_SBC_IMM: begin
            control.alu.operand_a_sel         = 1'b1;
            control.alu.operand_b_sel         = 1'b1;
            control.alu.invert_b              = (instruction == cpu_pkg::OP_SBC_IMM);
            control.alu.result_to_accumulator = 1'b1;
          end
          cpu_pkg::OP_LDA_ZP, cpu_pkg::OP_LDX_ZP, cpu_pkg::OP_LDY_ZP: begin
            control.increment_pc_to_pc      = 1'b0;
            control.increment_pc_to_address = 1'b0;
            control.data_to_address_low     = 1'b1;
            control.zero_page_high          = 1'b1;
            next_stage                      = cpu_pkg::FINISH;
          end
          cpu_pkg::OP_STA_ZP: begin
            control.increment_pc_to_pc      = 1'b0;
            control.increment_pc_to_address = 1'b0;
            control.data_to_address_low     = 1'b1;
            control.zero_page_high          = 1'b1;
            control.a_to_data               = 1'b1;
            control.bus_read                = 1'b0;
            control.bus_write               = 1'b1;
            next_stage                      = cpu_pkg::FINISH;
          end
          cpu_pkg::OP_JMP_ABS: begin
            // Keep PC on the low operand so the address moves to the high one
            control.increment_pc_to_pc = 1'b0;
            control.data_to_pc_low     = 1'b1;
            next_stage                 = cpu_pkg::FINISH;
          end
          default: begin
            needs_data = 1'b0;
          end
        endcase
      end

      cpu_pkg::FINISH: begin
        control.bus_read                = 1'b1;
        control.increment_pc_to_pc      = 1'b1;
        control.increment_pc_to_address = 1'b1;
        next_stage                      = cpu_pkg::FETCH;
        case (instruction)
          cpu_pkg::OP_LDA_ZP: begin
            control.data_to_a  = 1'b1;
            control.load_flags = 1'b1;
          end
          cpu_pkg::OP_LDX_ZP: begin
            control.data_to_x  = 1'b1;
            control.load_flags = 1'b1;
          end
          cpu_pkg::OP_LDY_ZP: begin
            control.data_to_y  = 1'b1;
            control.load_flags = 1'b1;
          end
          cpu_pkg::OP_JMP_ABS: begin
            control.increment_pc_to_pc      = 1'b0;
            control.increment_pc_to_address = 1'b0;
            control.data_to_pc_high         = 1'b1;
            control.pc_to_address           = 1'b1;
            control.data_to_address_high    = 1'b1;
          end
          default: begin
            needs_data = 1'b0;
          end
        endcase
      end

      default: begin
        needs_data = 1'b0;
        next_stage = cpu_pkg::VECTOR_LOW;
      end
    endcase
  end

  // A step that needs memory stalls until data_valid_i
  assign advance   = step_tick_i && (data_valid_i || !needs_data);
  assign control_o = advance ? control : '0;

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      stage <= cpu_pkg::VECTOR_LOW;
    end else if (advance) begin
      stage <= next_stage;
    end
  end

  always_ff @(posedge clock_i) begin
    if (advance && latch_opcode) begin
      instruction <= cpu_pkg::opcode_e'(data_i);
    end
  end

endmodule : cpu_sequencer

`default_nettype wire

// ==== verilog/cpu_top.sv ====
`default_nettype none

module cpu_top #(
  parameter int unsigned CLOCK_DIVIDER = 12
) (
  input  wire                 clock_i,
  input  wire                 reset_i,
  input  wire cpu_pkg::byte_t data_i,
  input  wire                 data_valid_i,
  output cpu_pkg::byte_t      data_o,
  output cpu_pkg::addr_t      address_o,
  output logic                bus_read_o,
  output logic                bus_write_o
);

  logic              step_tick;
  cpu_pkg::control_t control;
  cpu_pkg::byte_t    alu_a;
  cpu_pkg::byte_t    alu_b;
  logic              alu_carry;
  logic              alu_invert;
  cpu_pkg::status_t  alu_status;
  cpu_pkg::byte_t    alu_result;
  cpu_pkg::status_t  alu_flags;

  cpu_clock_enable #(
    .CLOCK_DIVIDER(CLOCK_DIVIDER)
  ) clock_enable_inst (
    .clock_i    (clock_i),
    .reset_i    (reset_i),
    .step_tick_o(step_tick)
  );

  cpu_sequencer sequencer_inst (
    .clock_i     (clock_i),
    .reset_i     (reset_i),
    .step_tick_i (step_tick),
    .data_i      (data_i),
    .data_valid_i(data_valid_i),
    .control_o   (control)
  );

  cpu_datapath datapath_inst (
    .clock_i     (clock_i),
    .reset_i     (reset_i),
    .control_i   (control),
    .data_i      (data_i),
    .alu_result_i(alu_result),
    .alu_flags_i (alu_flags),
    .alu_a_o     (alu_a),
    .alu_b_o     (alu_b),
    .alu_carry_o (alu_carry),
    .alu_invert_o(alu_invert),
    .alu_status_o(alu_status),
    .address_o   (address_o),
    .data_o      (data_o),
    .bus_read_o  (bus_read_o),
    .bus_write_o (bus_write_o)
  );

  cpu_alu alu_inst (
    .a_i     (alu_a),
    .b_i     (alu_b),
    .carry_i (alu_carry),
    .invert_i(alu_invert),
    .status_i(alu_status),
    .result_o(alu_result),
    .flags_o (alu_flags)
  );

endmodule : cpu_top

`default_nettype wire
